/* all.f */
+incdir+hw
hw/bus_pkg.sv
hw/pwm_pkg.sv
hw/synchronizer.sv
hw/heartbeat_led.sv
hw/up_interface.sv
hw/pwm_channel.sv
hw/motion_system.sv
bench/tb_motion_system.sv

/* run_sim.sh */
#!/bin/sh
# build the motion control testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_motion_system -Mdir obj_dir
./obj_dir/Vtb_motion_system | tee sim.log

if grep -q "Test completed successfully" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* bench/tb_motion_system.sv */
// testbench for the motion control top level
// processor bus model, register model, pwm, bridge and heartbeat checks
`timescale 1ns/1ps
`include "motion_macros.svh"

module tb_motion_system;

   localparam int NCH            = `NOS_PWM_CHANNELS;
   localparam int NREGS          = 3;
   localparam int IDX_PERIOD     = int'(pwm_pkg::REG_PERIOD);
   localparam int IDX_ON_TIME    = int'(pwm_pkg::REG_ON_TIME);
   localparam int IDX_CONFIG     = int'(pwm_pkg::REG_CONFIG);
   // ~110 transactions plus pwm windows, with margin
   localparam int TIMEOUT_CYCLES = 40000;

   logic           clk = 1'b0;
   logic           rst_n;
   logic           start, hs1, rw;
   logic           data_oe;
   logic [7:0]     data_out;
   wire  [7:0]     up_data;
   logic           up_ack, up_hs2;
   logic [NCH-1:0] pwm_out, h_bridge_1, h_bridge_2;
   logic           led1, led2;

   // register model, per channel checker enable
   pwm_pkg::pwm_reg_word_u model_regs [NCH][NREGS];
   logic [NCH-1:0]         check_mask;
   int                     ticks = 0;
   int                     cycle_count = 0;
   int                     seed;

   // processor side of the shared data bus
   assign up_data = data_oe ? data_out : 8'bz;

   motion_system uut (
      .CLOCK_50(clk), .rst_n(rst_n),
      .async_uP_start(start), .async_uP_handshake_1(hs1), .async_uP_RW(rw),
      .uP_ack(up_ack), .uP_handshake_2(up_hs2), .uP_data(up_data),
      .pwm_out(pwm_out), .H_bridge_1(h_bridge_1), .H_bridge_2(h_bridge_2),
      .led1(led1), .led2(led2)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   // clocks since reset release, for the heartbeat
   always @(posedge clk) begin
      if (!rst_n) begin
         ticks <= 0;
      end else begin
         ticks <= ticks + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("simulation timed out after %0d cycles", cycle_count);
         $display("Test failed");
         $fatal(1, "no progress");
      end
   end

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(input string name, input pwm_pkg::pwm_reg_word_u exp,
                             input pwm_pkg::pwm_reg_word_u act);
      if (act !== exp) begin
         $display("Error at %0t ns: %s expected 0x%04h, got 0x%04h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   // expected pwm high count per window and bridge pair, from the model
   function automatic void expected_outputs(input int ch, input logic pwm_now,
                                            output int high_count, output logic pwm_fixed,
                                            output logic pwm_exp, output logic br1_exp,
                                            output logic br2_exp);
      pwm_pkg::pwm_reg_word_u cfg;
      int window;
      int on_time;
      cfg     = model_regs[ch][IDX_CONFIG];
      window  = int'(model_regs[ch][IDX_PERIOD].count) + 1;
      on_time = int'(model_regs[ch][IDX_ON_TIME].count);
      if (!cfg.cfg.enable) begin
         high_count = 0;
      end else if (on_time < window) begin
         high_count = on_time;
      end else begin
         high_count = window;
      end
      // never high or always high, level known every clock
      pwm_fixed = (high_count == 0) || (high_count == window);
      pwm_exp   = (high_count == window);
      br1_exp   = 1'b0;
      br2_exp   = 1'b0;
      case (cfg.cfg.mode)
         pwm_pkg::MODE_FORWARD: br1_exp = pwm_now;
         pwm_pkg::MODE_REVERSE: br2_exp = pwm_now;
         pwm_pkg::MODE_BRAKE: begin
            br1_exp = cfg.cfg.enable;
            br2_exp = cfg.cfg.enable;
         end
         default: ;
      endcase
   endfunction

   // read-back value, 0 outside the register map
   function automatic pwm_pkg::pwm_reg_word_u model_read(input int ch, input int idx);
      if (ch < NCH && idx < NREGS) begin
         return model_regs[ch][idx];
      end
      return '0;
   endfunction

   function automatic logic [7:0] command_byte(input int ch, input int idx);
      logic [7:0] cmd;
      cmd = '0;
      cmd[bus_pkg::CHAN_MSB:bus_pkg::CHAN_LSB] = 4'(ch);
      cmd[bus_pkg::REG_MSB:bus_pkg::REG_LSB]   = 4'(idx);
      return cmd;
   endfunction

   function automatic pwm_pkg::pwm_reg_word_u random_word(input int limit);
      pwm_pkg::pwm_reg_word_u w;
      w.count = 16'($unsigned($random(seed)) % limit);
      return w;
   endfunction

   // reserved bits random
   function automatic pwm_pkg::pwm_reg_word_u config_word(input logic [1:0] mode,
                                                          input logic enable);
      pwm_pkg::pwm_reg_word_u w;
      w            = random_word(65536);
      w.cfg.mode   = mode;
      w.cfg.enable = enable;
      return w;
   endfunction

   task automatic wait_hs2(input logic level);
      @(negedge clk);
      while (up_hs2 !== level) @(negedge clk);
   endtask

   // one four-phase byte handshake
   task automatic byte_phase(input logic is_read, input logic [7:0] wbyte,
                             output logic [7:0] rbyte);
      @(posedge clk);
      rw       <= is_read;
      data_oe  <= !is_read;
      data_out <= wbyte;
      hs1      <= 1'b1;
      wait_hs2(1'b1);
      rbyte = up_data;
      @(posedge clk);
      hs1 <= 1'b0;
      wait_hs2(1'b0);
   endtask

   // command byte, then low and high data byte
   task automatic bus_transaction(input logic is_read, input logic [7:0] cmd,
                                  input logic [15:0] wdata, output logic [15:0] rdata);
      logic [7:0] lo, hi, cmd_echo;
      @(posedge clk);
      start <= 1'b1;
      @(negedge clk);
      while (!up_ack) @(negedge clk);
      byte_phase(1'b0, cmd, cmd_echo);
      byte_phase(is_read, wdata[7:0], lo);
      byte_phase(is_read, wdata[15:8], hi);
      @(posedge clk);
      start   <= 1'b0;
      rw      <= 1'b0;
      data_oe <= 1'b0;
      @(negedge clk);
      while (up_ack) @(negedge clk);
      rdata = {hi, lo};
   endtask

   task automatic write_reg(input int ch, input int idx, input pwm_pkg::pwm_reg_word_u w);
      logic [15:0] rdata;
      // written channel in flux until the model catches up
      if (ch < NCH) check_mask[ch] <= 1'b0;
      bus_transaction(1'b0, command_byte(ch, idx), w.count, rdata);
      if (ch < NCH && idx < NREGS) model_regs[ch][idx] <= w;
      if (ch < NCH) check_mask[ch] <= 1'b1;
      @(negedge clk);
   endtask

   task automatic read_reg(input int ch, input int idx);
      logic [15:0]            rdata;
      pwm_pkg::pwm_reg_word_u got;
      bus_transaction(1'b1, command_byte(ch, idx), 16'h0000, rdata);
      got.count = rdata;
      check_word($sformatf("uP_data ch %0d reg %0d", ch, idx), model_read(ch, idx), got);
   endtask

   task automatic count_high(input int ch, input int cycles, output int high);
      high = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (pwm_out[ch]) high++;
      end
   endtask

   function automatic int window_of(input int ch);
      return int'(model_regs[ch][IDX_PERIOD].count) + 1;
   endfunction

   // outputs against the model on every falling edge
   always @(negedge clk) begin : compare_outputs
      int   hc;
      logic fixed, pexp, b1, b2;
      check_level("led2", rst_n, led2);
      check_level("led1", 1'((ticks >> `HEARTBEAT_BITS) & 1), led1);
      for (int ch = 0; ch < NCH; ch++) begin
         if (check_mask[ch]) begin
            expected_outputs(ch, pwm_out[ch], hc, fixed, pexp, b1, b2);
            if (fixed) check_level($sformatf("pwm_out[%0d]", ch), pexp, pwm_out[ch]);
            check_level($sformatf("H_bridge_1[%0d]", ch), b1, h_bridge_1[ch]);
            check_level($sformatf("H_bridge_2[%0d]", ch), b2, h_bridge_2[ch]);
         end
      end
   end

   initial begin : main_sequence
      int   ch, high, exp_high, settle;
      logic fixed, pexp, b1, b2;
      seed        = 47;
      rst_n       = 1'b0;
      start       = 1'b0;
      hs1         = 1'b0;
      rw          = 1'b0;
      data_oe     = 1'b0;
      data_out    = '0;
      check_mask  = '1;
      for (int c = 0; c < NCH; c++) begin
         for (int r = 0; r < NREGS; r++) model_regs[c][r] = '0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(negedge clk);

      // reset state
      check_level("uP_ack", 1'b0, up_ack);
      check_level("uP_handshake_2", 1'b0, up_hs2);
      for (int c = 0; c < NCH; c++) begin
         check_level($sformatf("pwm_out[%0d]", c), 1'b0, pwm_out[c]);
         for (int r = 0; r < NREGS; r++) read_reg(c, r);
      end

      // read-back, unmapped index and missing channel
      for (int c = 0; c < NCH; c++) begin
         write_reg(c, IDX_PERIOD, random_word(65536));
         write_reg(c, IDX_ON_TIME, random_word(65536));
         write_reg(c, IDX_CONFIG, config_word(2'($random(seed)), 1'($random(seed))));
         for (int r = 0; r < NREGS; r++) read_reg(c, r);
         write_reg(c, 3, random_word(65536));
         read_reg(c, 3);
      end
      if (NCH < 16) read_reg(NCH, IDX_PERIOD);

      // duty cycle, one settling window then one measured window
      for (int i = 0; i < 16; i++) begin
         ch = i % NCH;
         write_reg(ch, IDX_PERIOD, random_word(256));
         write_reg(ch, IDX_ON_TIME, random_word(301));
         write_reg(ch, IDX_CONFIG, config_word(pwm_pkg::MODE_FORWARD, 1'b1));
         expected_outputs(ch, 1'b0, exp_high, fixed, pexp, b1, b2);
         count_high(ch, window_of(ch), settle);
         count_high(ch, window_of(ch), high);
         check_count($sformatf("pwm_out[%0d] high cycles", ch), exp_high, high);
      end

      // bridge modes, lines compared every clock by compare_outputs
      for (int c = 0; c < NCH; c++) begin
         for (int m = 0; m < 4; m++) begin
            write_reg(c, IDX_PERIOD, random_word(64));
            write_reg(c, IDX_ON_TIME, random_word(66));
            write_reg(c, IDX_CONFIG, config_word(2'(m), 1'b1));
            count_high(c, 2 * window_of(c), settle);
         end
         // enable off overrides even brake
         write_reg(c, IDX_CONFIG, config_word(pwm_pkg::MODE_BRAKE, 1'b0));
         count_high(c, 4, high);
         check_count($sformatf("pwm_out[%0d] high cycles disabled", c), 0, high);
         check_level($sformatf("H_bridge_1[%0d]", c), 1'b0, h_bridge_1[c]);
         check_level($sformatf("H_bridge_2[%0d]", c), 1'b0, h_bridge_2[c]);
      end

      // other channels keep registers, outputs checked meanwhile
      for (int c = 0; c < NCH; c++) begin
         write_reg(c, IDX_PERIOD, random_word(256));
         write_reg(c, IDX_ON_TIME, random_word(256));
         write_reg(c, IDX_CONFIG, config_word(2'($random(seed)), 1'b1));
         for (int o = 0; o < NCH; o++) begin
            if (o != c) begin
               for (int r = 0; r < NREGS; r++) read_reg(o, r);
            end
         end
      end

      repeat (8) @(negedge clk);
      $display("Test completed successfully");
      $finish;
   end

endmodule

/* hw/motion_system.sv */
// motion control top level
// strobe synchronizers, microprocessor bus interface, heartbeat and pwm channels
`timescale 1ns/1ps
`include "motion_macros.svh"

module motion_system (
   input  logic                         CLOCK_50,
   input  logic                         rst_n,
   input  logic                         async_uP_start,
   input  logic                         async_uP_handshake_1,
   input  logic                         async_uP_RW,
   output logic                         uP_ack,
   output logic                         uP_handshake_2,
   inout  wire  [7:0]                   uP_data,
   output logic [`NOS_PWM_CHANNELS-1:0] pwm_out,
   output logic [`NOS_PWM_CHANNELS-1:0] H_bridge_1,
   output logic [`NOS_PWM_CHANNELS-1:0] H_bridge_2,
   output logic                         led1,
   output logic                         led2
);

   logic                                          uP_start, uP_handshake_1, uP_RW;
   logic [3:0]                                    bus_chan, bus_reg;
   logic [`REG_WIDTH-1:0]                         bus_wdata;
   logic                                          bus_write;
   pwm_pkg::pwm_reg_word_u [`NOS_PWM_CHANNELS-1:0] bus_rdata;

   // reset released indicator
   assign led2 = rst_n;

   heartbeat_led flash (.clk(CLOCK_50), .rst_n(rst_n), .led(led1));

   // processor strobes into the 50 MHz domain
   synchronizer sync_start (
      .clk(CLOCK_50), .rst_n(rst_n), .async_in(async_uP_start), .sync_out(uP_start)
   );
   synchronizer sync_handshake_1 (
      .clk(CLOCK_50), .rst_n(rst_n), .async_in(async_uP_handshake_1), .sync_out(uP_handshake_1)
   );
   synchronizer sync_rw (
      .clk(CLOCK_50), .rst_n(rst_n), .async_in(async_uP_RW), .sync_out(uP_RW)
   );

   up_interface up_if (
      .clk(CLOCK_50), .rst_n(rst_n),
      .uP_start(uP_start), .uP_handshake_1(uP_handshake_1), .uP_RW(uP_RW),
      .uP_ack(uP_ack), .uP_handshake_2(uP_handshake_2), .uP_data(uP_data),
      .bus_chan(bus_chan), .bus_reg(bus_reg), .bus_wdata(bus_wdata),
      .bus_write(bus_write), .bus_rdata(bus_rdata)
   );

   // one channel per pwm output
   for (genvar unit = 0; unit < `NOS_PWM_CHANNELS; unit++) begin : pwm_h_bridge
      pwm_channel #(.PWM_UNIT(unit)) pwm_ch (
         .clk(CLOCK_50), .rst_n(rst_n),
         .bus_chan(bus_chan), .bus_reg(bus_reg), .bus_wdata(bus_wdata),
         .bus_write(bus_write), .bus_rdata(bus_rdata[unit]),
         .pwm_signal(pwm_out[unit]),
         .H_bridge_1(H_bridge_1[unit]),
         .H_bridge_2(H_bridge_2[unit])
      );
   end

endmodule

/* hw/pwm_channel.sv */
// pwm channel
// period, on_time and config registers, period counter, duty
// comparator and H-bridge steering, all outputs registered
`timescale 1ns/1ps
`include "motion_macros.svh"

module pwm_channel #(
   parameter int PWM_UNIT = 0
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [3:0]             bus_chan,
   input  logic [3:0]             bus_reg,
   input  logic [`REG_WIDTH-1:0]  bus_wdata,
   input  logic                   bus_write,
   output pwm_pkg::pwm_reg_word_u bus_rdata,
   output logic                   pwm_signal,
   output logic                   H_bridge_1,
   output logic                   H_bridge_2
);

   pwm_pkg::pwm_reg_word_u period_q, on_time_q, config_q;
   pwm_pkg::pwm_reg_word_u period_d, on_time_d, config_d;
   logic [`REG_WIDTH-1:0]  count_q, count_d;
   logic                   chan_sel;
   logic                   pwm_d, bridge_1_d, bridge_2_d;

   assign chan_sel = bus_write && (bus_chan == 4'(PWM_UNIT));

   // register file next state
   always_comb begin
      period_d  = period_q;
      on_time_d = on_time_q;
      config_d  = config_q;
      if (chan_sel) begin
         case (bus_reg)
            pwm_pkg::REG_PERIOD:  period_d.count  = bus_wdata;
            pwm_pkg::REG_ON_TIME: on_time_d.count = bus_wdata;
            pwm_pkg::REG_CONFIG:  config_d.count  = bus_wdata;
            default: ;
         endcase
      end
   end

   // counter 0..period, parked at 0 until enable has been on a clock
   // outputs come from the next-state values so a write shows next cycle
   always_comb begin
      if (!(config_q.cfg.enable && config_d.cfg.enable)) begin
         count_d = '0;
      end else if (count_q >= period_d.count) begin
         count_d = '0;
      end else begin
         count_d = count_q + 1'b1;
      end
      pwm_d = config_d.cfg.enable && (count_d < on_time_d.count);
   end

   // bridge steering
   always_comb begin
      bridge_1_d = 1'b0;
      bridge_2_d = 1'b0;
      case (config_d.cfg.mode)
         pwm_pkg::MODE_FORWARD: bridge_1_d = pwm_d;
         pwm_pkg::MODE_REVERSE: bridge_2_d = pwm_d;
         pwm_pkg::MODE_BRAKE: begin
            // both low-side paths on, motor shorted
            bridge_1_d = config_d.cfg.enable;
            bridge_2_d = config_d.cfg.enable;
         end
         pwm_pkg::MODE_COAST: begin
            bridge_1_d = 1'b0;
            bridge_2_d = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         period_q   <= '0;
         on_time_q  <= '0;
         config_q   <= '0;
         count_q    <= '0;
         pwm_signal <= 1'b0;
         H_bridge_1 <= 1'b0;
         H_bridge_2 <= 1'b0;
      end else begin
         period_q   <= period_d;
         on_time_q  <= on_time_d;
         config_q   <= config_d;
         count_q    <= count_d;
         pwm_signal <= pwm_d;
         H_bridge_1 <= bridge_1_d;
         H_bridge_2 <= bridge_2_d;
      end
   end

   // read-back follows bus_reg
   always_comb begin
      case (bus_reg)
         pwm_pkg::REG_PERIOD:  bus_rdata = period_q;
         pwm_pkg::REG_ON_TIME: bus_rdata = on_time_q;
         pwm_pkg::REG_CONFIG:  bus_rdata = config_q;
         default:              bus_rdata = '0;
      endcase
   end

endmodule

/* hw/up_interface.sv */
// microprocessor bus interface
// four-phase strobe handshake, command byte plus two data bytes,
// turned into register reads and writes on the internal bus
`timescale 1ns/1ps
`include "motion_macros.svh"

module up_interface (
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic                                           uP_start,
   input  logic                                           uP_handshake_1,
   input  logic                                           uP_RW,
   output logic                                           uP_ack,
   output logic                                           uP_handshake_2,
   inout  wire  [7:0]                                     uP_data,
   output logic [3:0]                                     bus_chan,
   output logic [3:0]                                     bus_reg,
   output logic [`REG_WIDTH-1:0]                          bus_wdata,
   output logic                                           bus_write,
   input  pwm_pkg::pwm_reg_word_u [`NOS_PWM_CHANNELS-1:0] bus_rdata
);

   // fsm states
   localparam logic [2:0] S_IDLE          = 3'd0;
   localparam logic [2:0] S_WAIT_HS1_HIGH = 3'd1;
   localparam logic [2:0] S_CAPTURE       = 3'd2;
   localparam logic [2:0] S_WAIT_HS1_LOW  = 3'd3;
   localparam logic [2:0] S_DONE          = 3'd4;

   // byte phase within a transaction
   localparam logic [1:0] BYTE_CMD  = 2'd0;
   localparam logic [1:0] BYTE_LOW  = 2'd1;
   localparam logic [1:0] BYTE_HIGH = 2'(bus_pkg::BYTES_PER_WORD);

   logic [2:0]             state;
   logic [1:0]             byte_cnt;
   logic                   is_read;
   pwm_pkg::pwm_reg_word_u read_word;
   pwm_pkg::pwm_reg_word_u rd_word;
   logic [7:0]             rd_byte;

   assign is_read = (uP_RW == bus_pkg::RW_READ);

   // word of the addressed channel
   // zero for a channel that does not exist
   always_comb begin
      read_word = '0;
      for (int i = 0; i < `NOS_PWM_CHANNELS; i++) begin
         if (bus_chan == 4'(i)) begin
            read_word = bus_rdata[i];
         end
      end
   end

   // low byte in phase one, high byte in phase two
   assign rd_byte = (byte_cnt == BYTE_HIGH) ? rd_word.count[15:8] : rd_word.count[7:0];

   // drive the shared bus only during an acknowledged read
   assign uP_data = (uP_ack && is_read) ? rd_byte : 8'bz;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state          <= S_IDLE;
         byte_cnt       <= BYTE_CMD;
         uP_ack         <= 1'b0;
         uP_handshake_2 <= 1'b0;
         bus_chan       <= '0;
         bus_reg        <= '0;
         bus_write      <= 1'b0;
      end else begin
         // write strobe lasts one clock
         bus_write <= 1'b0;
         case (state)
            S_IDLE: begin
               if (uP_start) begin
                  uP_ack   <= 1'b1;
                  byte_cnt <= BYTE_CMD;
                  state    <= S_WAIT_HS1_HIGH;
               end
            end
            S_WAIT_HS1_HIGH: begin
               // start dropped early, give up the transaction
               if (!uP_start) begin
                  uP_ack <= 1'b0;
                  state  <= S_IDLE;
               end else if (uP_handshake_1) begin
                  state <= S_CAPTURE;
               end
            end
            S_CAPTURE: begin
               uP_handshake_2 <= 1'b1;
               state          <= S_WAIT_HS1_LOW;
               if (byte_cnt == BYTE_CMD) begin
                  bus_chan <= uP_data[bus_pkg::CHAN_MSB:bus_pkg::CHAN_LSB];
                  bus_reg  <= uP_data[bus_pkg::REG_MSB:bus_pkg::REG_LSB];
               end else if (byte_cnt == BYTE_HIGH && !is_read) begin
                  // high byte lands in bus_wdata on this same edge
                  bus_write <= 1'b1;
               end
            end
            S_WAIT_HS1_LOW: begin
               if (!uP_handshake_1) begin
                  uP_handshake_2 <= 1'b0;
                  if (byte_cnt == BYTE_HIGH) begin
                     state <= S_DONE;
                  end else begin
                     byte_cnt <= byte_cnt + 2'd1;
                     state    <= S_WAIT_HS1_HIGH;
                  end
               end
            end
            S_DONE: begin
               // ack held until the processor ends the transaction
               if (!uP_start) begin
                  uP_ack <= 1'b0;
                  state  <= S_IDLE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // data path, write bytes and the latched read word
   always_ff @(posedge clk) begin
      if (state == S_CAPTURE && !is_read) begin
         if (byte_cnt == BYTE_LOW) begin
            bus_wdata[7:0] <= uP_data;
         end
         if (byte_cnt == BYTE_HIGH) begin
            bus_wdata[15:8] <= uP_data;
         end
      end
      // channel and register settle after the command byte
      if (state == S_WAIT_HS1_LOW && byte_cnt == BYTE_CMD) begin
         rd_word <= read_word;
      end
   end

endmodule

/* hw/heartbeat_led.sv */
// heartbeat led
// free-running counter, its carry toggles the alive led
`timescale 1ns/1ps
`include "motion_macros.svh"

module heartbeat_led (
   input  logic clk,
   input  logic rst_n,
   output logic led
);

   logic [`HEARTBEAT_BITS-1:0] beat_count;
   // one extra bit for the carry out
   logic [`HEARTBEAT_BITS:0]   beat_next;

   assign beat_next = {1'b0, beat_count} + 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_count <= '0;
         led        <= 1'b0;
      end else begin
         beat_count <= beat_next[`HEARTBEAT_BITS-1:0];
         // wrap of the counter
         if (beat_next[`HEARTBEAT_BITS]) begin
            led <= ~led;
         end
      end
   end

endmodule

/* hw/synchronizer.sv */
// strobe synchronizer
// shift chain that brings one asynchronous input into the clock domain
`timescale 1ns/1ps
`include "motion_macros.svh"

module synchronizer (
   input  logic clk,
   input  logic rst_n,
   input  logic async_in,
   output logic sync_out
);

   // stage 0 may go metastable, later stages settle it
   logic [`SYNC_STAGES-1:0] sync_chain;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_chain <= '0;
      end else begin
         sync_chain <= {sync_chain[`SYNC_STAGES-2:0], async_in};
      end
   end

   assign sync_out = sync_chain[`SYNC_STAGES-1];

endmodule

/* hw/pwm_pkg.sv */
// pwm channel register map, bridge modes and register word layout
`include "motion_macros.svh"

package pwm_pkg;

   // register index inside a channel
   // other indices read 0, writes dropped
   localparam logic [3:0] REG_PERIOD  = 4'd0;
   localparam logic [3:0] REG_ON_TIME = 4'd1;
   localparam logic [3:0] REG_CONFIG  = 4'd2;

   // H-bridge drive modes, config bits 2..1
   localparam logic [1:0] MODE_COAST   = 2'd0;
   localparam logic [1:0] MODE_FORWARD = 2'd1;
   localparam logic [1:0] MODE_REVERSE = 2'd2;
   localparam logic [1:0] MODE_BRAKE   = 2'd3;

   // one register word, as a plain count or as config fields
   typedef union packed {
      logic [`REG_WIDTH-1:0] count;
      struct packed {
         // kept as written, no function
         logic [`REG_WIDTH-4:0] reserved;
         logic [1:0]            mode;
         logic                  enable;
      } cfg;
   } pwm_reg_word_u;

endpackage

/* hw/bus_pkg.sv */
// microprocessor bus protocol encodings
// command byte layout and transaction framing
package bus_pkg;

   // command byte, upper nibble selects the channel
   localparam int CHAN_MSB = 7;
   localparam int CHAN_LSB = 4;

   // lower nibble selects the register inside the channel
   localparam int REG_MSB = 3;
   localparam int REG_LSB = 0;

   // data bytes after the command, low byte first
   localparam int BYTES_PER_WORD = 2;

   // level of uP_RW for a read
   // low means the processor writes
   localparam logic RW_READ = 1'b1;

endpackage

/* hw/motion_macros.svh */
// motion control build parameters
// channel count, synchronizer depth, heartbeat rate and register width
`ifndef MOTION_MACROS_SVH
`define MOTION_MACROS_SVH

// number of pwm channels, at most 16 (4-bit channel field)
`define NOS_PWM_CHANNELS 2

// flip-flops per strobe synchronizer, 2 or more
`define SYNC_STAGES 2

// alive led toggles every 2^HEARTBEAT_BITS clocks
// 24 gives roughly 3 Hz at 50 MHz
`define HEARTBEAT_BITS 24

// width of one channel register
`define REG_WIDTH 16

`endif
